//--- hw/ex_pkg.sv
package ex_pkg;

    localparam int WORD_W = 32;

    // instruction field positions
    localparam int SHAMT_LSB = 6;
    localparam int RT_LSB = 16;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [2*WORD_W-1:0] dword_t;
    typedef logic [4:0] reg_idx_t;

    localparam reg_idx_t LINK_REG = 5'd31;
    localparam reg_idx_t ZERO_REG = 5'd0;

    typedef enum logic [7:0] {
        ALUOP_NOP    = 8'h00,
        // arithmetic and compare
        ALUOP_ADD    = 8'h01,
        ALUOP_ADDI   = 8'h02,
        ALUOP_ADDU   = 8'h03,
        ALUOP_ADDIU  = 8'h04,
        ALUOP_SUB    = 8'h05,
        ALUOP_SUBU   = 8'h06,
        ALUOP_SLT    = 8'h07,
        ALUOP_SLTI   = 8'h08,
        ALUOP_SLTU   = 8'h09,
        ALUOP_SLTIU  = 8'h0a,
        // logic and shifts
        ALUOP_AND    = 8'h10,
        ALUOP_ANDI   = 8'h11,
        ALUOP_OR     = 8'h12,
        ALUOP_ORI    = 8'h13,
        ALUOP_XOR    = 8'h14,
        ALUOP_XORI   = 8'h15,
        ALUOP_NOR    = 8'h16,
        ALUOP_LUI    = 8'h17,
        ALUOP_SLL    = 8'h18,
        ALUOP_SLLV   = 8'h19,
        ALUOP_SRL    = 8'h1a,
        ALUOP_SRLV   = 8'h1b,
        ALUOP_SRA    = 8'h1c,
        ALUOP_SRAV   = 8'h1d,
        // links
        ALUOP_JAL    = 8'h20,
        ALUOP_JALR   = 8'h21,
        ALUOP_BGEZAL = 8'h22,
        ALUOP_BLTZAL = 8'h23,
        // hi/lo unit
        ALUOP_MFHI   = 8'h30,
        ALUOP_MFLO   = 8'h31,
        ALUOP_MTHI   = 8'h32,
        ALUOP_MTLO   = 8'h33,
        ALUOP_MULT   = 8'h34,
        ALUOP_MULTU  = 8'h35,
        ALUOP_DIV    = 8'h36,
        ALUOP_DIVU   = 8'h37,
        // loads and stores
        ALUOP_LB     = 8'h40,
        ALUOP_LBU    = 8'h41,
        ALUOP_LH     = 8'h42,
        ALUOP_LHU    = 8'h43,
        ALUOP_LW     = 8'h44,
        ALUOP_SB     = 8'h45,
        ALUOP_SH     = 8'h46,
        ALUOP_SW     = 8'h47
    } aluop_e;

endpackage

//--- hw/hilo_bypass_if.sv
`timescale 1ns/1ps

interface hilo_bypass_if import ex_pkg::*; ();

    logic  hi_we;
    word_t hi_data;
    logic  lo_we;
    word_t lo_data;

    modport source (
        output hi_we, hi_data, lo_we, lo_data
    );

    modport sink (
        input hi_we, hi_data, lo_we, lo_data
    );

endinterface

//--- hw/hilo_forward.sv
`timescale 1ns/1ps

module hilo_forward import ex_pkg::*; (
    input  aluop_e               aluop_i,
    input  word_t                hilo_data_i,
    hilo_bypass_if.sink          mem_bp,
    hilo_bypass_if.sink          wb_bp,
    output word_t                hilo_fwd_o
);

    always_comb begin
        hilo_fwd_o = hilo_data_i;
        if (aluop_i == ALUOP_MFHI) begin
            if (mem_bp.hi_we) begin
                hilo_fwd_o = mem_bp.hi_data;
            end else if (wb_bp.hi_we) begin
                hilo_fwd_o = wb_bp.hi_data;
            end
        end else begin
            // lo side, newest stage first
            if (mem_bp.lo_we) begin
                hilo_fwd_o = mem_bp.lo_data;
            end else if (wb_bp.lo_we) begin
                hilo_fwd_o = wb_bp.lo_data;
            end
        end
    end

endmodule

//--- hw/int_alu.sv
`timescale 1ns/1ps

module int_alu import ex_pkg::*; (
    input  aluop_e   aluop_i,
    input  word_t    instr_i,
    input  word_t    rs_data_i,
    input  word_t    rt_data_i,
    input  word_t    pc_return_i,
    input  word_t    hilo_fwd_i,
    input  reg_idx_t dest_addr_i,
    output word_t    alu_data_o,
    output reg_idx_t wb_addr_o,
    output logic     overflow_o
);

    logic [RT_LSB-1:0] imm16;
    word_t             imm_sext;
    word_t             imm_zext;
    word_t             imm_upper;
    logic [4:0]        shamt;
    word_t             sum_rt;
    word_t             sum_imm;
    word_t             diff;
    logic              add_ovf;
    logic              addi_ovf;
    logic              sub_ovf;

    // immediate is everything below the rt field
    assign imm16     = instr_i[RT_LSB-1:0];
    assign imm_sext  = {{(WORD_W-RT_LSB){imm16[RT_LSB-1]}}, imm16};
    assign imm_zext  = {{(WORD_W-RT_LSB){1'b0}}, imm16};
    assign imm_upper = {imm16, {(WORD_W-RT_LSB){1'b0}}};
    assign shamt     = instr_i[SHAMT_LSB +: 5];

    assign sum_rt  = rs_data_i + rt_data_i;
    assign sum_imm = rs_data_i + imm_sext;
    assign diff    = rs_data_i - rt_data_i;

    always_comb begin
        case (aluop_i)
            ALUOP_ADD, ALUOP_ADDU:   alu_data_o = sum_rt;
            ALUOP_ADDI, ALUOP_ADDIU: alu_data_o = sum_imm;
            ALUOP_SUB, ALUOP_SUBU:   alu_data_o = diff;
            ALUOP_SLT:   alu_data_o = word_t'($signed(rs_data_i) < $signed(rt_data_i));
            ALUOP_SLTI:  alu_data_o = word_t'($signed(rs_data_i) < $signed(imm_sext));
            ALUOP_SLTU:  alu_data_o = word_t'(rs_data_i < rt_data_i);
            // sltiu still compares against the sign-extended immediate
            ALUOP_SLTIU: alu_data_o = word_t'(rs_data_i < imm_sext);
            ALUOP_AND:   alu_data_o = rs_data_i & rt_data_i;
            ALUOP_ANDI:  alu_data_o = rs_data_i & imm_zext;
            ALUOP_OR:    alu_data_o = rs_data_i | rt_data_i;
            ALUOP_ORI:   alu_data_o = rs_data_i | imm_zext;
            ALUOP_XOR:   alu_data_o = rs_data_i ^ rt_data_i;
            ALUOP_XORI:  alu_data_o = rs_data_i ^ imm_zext;
            ALUOP_NOR:   alu_data_o = ~(rs_data_i | rt_data_i);
            ALUOP_LUI:   alu_data_o = imm_upper;
            ALUOP_SLL:   alu_data_o = rt_data_i << shamt;
            ALUOP_SLLV:  alu_data_o = rt_data_i << rs_data_i[4:0];
            ALUOP_SRL:   alu_data_o = rt_data_i >> shamt;
            ALUOP_SRLV:  alu_data_o = rt_data_i >> rs_data_i[4:0];
            ALUOP_SRA:   alu_data_o = $signed(rt_data_i) >>> shamt;
            ALUOP_SRAV:  alu_data_o = $signed(rt_data_i) >>> rs_data_i[4:0];
            ALUOP_JAL, ALUOP_JALR, ALUOP_BGEZAL, ALUOP_BLTZAL: alu_data_o = pc_return_i;
            ALUOP_MFHI, ALUOP_MFLO: alu_data_o = hilo_fwd_i;
            // effective address
            ALUOP_LB, ALUOP_LBU, ALUOP_LH, ALUOP_LHU, ALUOP_LW,
            ALUOP_SB, ALUOP_SH, ALUOP_SW: alu_data_o = sum_imm;
            default:     alu_data_o = '0;
        endcase
    end

    // same-sign operands with a flipped result sign
    assign add_ovf  = (rs_data_i[WORD_W-1] == rt_data_i[WORD_W-1])
                      && (sum_rt[WORD_W-1] != rs_data_i[WORD_W-1]);
    assign addi_ovf = (rs_data_i[WORD_W-1] == imm_sext[WORD_W-1])
                      && (sum_imm[WORD_W-1] != rs_data_i[WORD_W-1]);
    assign sub_ovf  = (rs_data_i[WORD_W-1] != rt_data_i[WORD_W-1])
                      && (diff[WORD_W-1] != rs_data_i[WORD_W-1]);

    assign overflow_o = ((aluop_i == ALUOP_ADD) && add_ovf)
                        || ((aluop_i == ALUOP_ADDI) && addi_ovf)
                        || ((aluop_i == ALUOP_SUB) && sub_ovf);

    always_comb begin
        if (overflow_o) begin
            wb_addr_o = ZERO_REG;
        end else if (aluop_i == ALUOP_JAL || aluop_i == ALUOP_BGEZAL
                     || aluop_i == ALUOP_BLTZAL) begin
            wb_addr_o = LINK_REG;
        end else begin
            wb_addr_o = dest_addr_i;
        end
    end

endmodule

//--- hw/hilo_result.sv
`timescale 1ns/1ps

module hilo_result import ex_pkg::*; (
    input  aluop_e aluop_i,
    input  word_t  rs_data_i,
    input  word_t  rt_data_i,
    input  word_t  quotient_i,
    input  word_t  remainder_i,
    output word_t  hi_data_o,
    output word_t  lo_data_o
);

    dword_t prod_s;
    dword_t prod_u;
    dword_t hilo;

    // operands widen to 64 bits before the multiply
    assign prod_s = $signed(rs_data_i) * $signed(rt_data_i);
    assign prod_u = {{WORD_W{1'b0}}, rs_data_i} * {{WORD_W{1'b0}}, rt_data_i};

    always_comb begin
        case (aluop_i)
            ALUOP_MULT:  hilo = prod_s;
            ALUOP_MULTU: hilo = prod_u;
            // one of the two halves gets written downstream
            ALUOP_MTHI, ALUOP_MTLO: hilo = {rs_data_i, rs_data_i};
            ALUOP_DIV, ALUOP_DIVU:  hilo = {remainder_i, quotient_i};
            default:     hilo = '0;
        endcase
    end

    assign hi_data_o = hilo[2*WORD_W-1:WORD_W];
    assign lo_data_o = hilo[WORD_W-1:0];

endmodule

//--- hw/seq_divider.sv
`timescale 1ns/1ps

module seq_divider import ex_pkg::*; #(
    parameter int DIV_CYCLES = 33
) (
    input  logic  clk,
    input  logic  rst_n_i,
    input  logic  start_i,
    input  logic  signed_i,
    input  word_t dividend_i,
    input  word_t divisor_i,
    output word_t quotient_o,
    output word_t remainder_o,
    output logic  done_o
);

    localparam int CNT_W = $clog2(DIV_CYCLES);

    typedef enum logic [1:0] {
        S_IDLE,
        S_BUSY,
        S_DONE
    } state_e;

    state_e          state;
    logic [CNT_W-1:0] cnt;
    word_t           quo;
    word_t           rem;
    word_t           dsor;
    logic            neg_q;
    logic            neg_r;
    word_t           dividend_mag;
    word_t           divisor_mag;
    logic [WORD_W:0] trial;

    assign dividend_mag = (signed_i && dividend_i[WORD_W-1]) ? -dividend_i : dividend_i;
    assign divisor_mag  = (signed_i && divisor_i[WORD_W-1]) ? -divisor_i : divisor_i;

    // shift in next dividend bit and try to subtract
    assign trial = {rem, quo[WORD_W-1]} - {1'b0, dsor};

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state <= S_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start_i) begin
                        state <= S_BUSY;
                        cnt   <= '0;
                    end
                end
                S_BUSY: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(DIV_CYCLES - 2)) begin
                        state <= S_DONE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && start_i) begin
            quo   <= dividend_mag;
            rem   <= '0;
            dsor  <= divisor_mag;
            neg_q <= signed_i && (dividend_i[WORD_W-1] != divisor_i[WORD_W-1]);
            neg_r <= signed_i && dividend_i[WORD_W-1];
        end else if (state == S_BUSY && int'(cnt) < WORD_W) begin
            // restoring step, extra cycles beyond the word width just wait
            if (!trial[WORD_W]) begin
                rem <= trial[WORD_W-1:0];
                quo <= {quo[WORD_W-2:0], 1'b1};
            end else begin
                rem <= {rem[WORD_W-2:0], quo[WORD_W-1]};
                quo <= {quo[WORD_W-2:0], 1'b0};
            end
        end
    end

    // truncate toward zero, remainder follows dividend
    assign quotient_o  = neg_q ? -quo : quo;
    assign remainder_o = neg_r ? -rem : rem;
    assign done_o      = (state == S_DONE);

endmodule

//--- hw/ex_stage.sv
`timescale 1ns/1ps

module ex_stage import ex_pkg::*; #(
    parameter int DIV_CYCLES = 33
) (
    input  logic     clk,
    input  logic     rst_n_i,
    input  aluop_e   aluop_i,
    input  word_t    instr_i,
    input  word_t    rs_data_i,
    input  word_t    rt_data_i,
    input  word_t    pc_return_i,
    input  word_t    hilo_data_i,
    input  reg_idx_t dest_addr_i,
    input  logic     mem_hi_we_i,
    input  logic     mem_lo_we_i,
    input  logic     wb_hi_we_i,
    input  logic     wb_lo_we_i,
    input  word_t    mem_hi_data_i,
    input  word_t    mem_lo_data_i,
    input  word_t    wb_hi_data_i,
    input  word_t    wb_lo_data_i,
    output word_t    alu_data_o,
    output reg_idx_t wb_addr_o,
    output logic     overflow_o,
    output word_t    hi_data_o,
    output word_t    lo_data_o,
    output logic     stall_o
);

    hilo_bypass_if mem_bp ();
    hilo_bypass_if wb_bp ();

    word_t hilo_fwd;
    word_t quotient;
    word_t remainder;
    logic  is_div;
    logic  div_signed;
    logic  div_done;

    assign mem_bp.hi_we   = mem_hi_we_i;
    assign mem_bp.hi_data = mem_hi_data_i;
    assign mem_bp.lo_we   = mem_lo_we_i;
    assign mem_bp.lo_data = mem_lo_data_i;
    assign wb_bp.hi_we    = wb_hi_we_i;
    assign wb_bp.hi_data  = wb_hi_data_i;
    assign wb_bp.lo_we    = wb_lo_we_i;
    assign wb_bp.lo_data  = wb_lo_data_i;

    assign is_div     = (aluop_i == ALUOP_DIV) || (aluop_i == ALUOP_DIVU);
    assign div_signed = (aluop_i == ALUOP_DIV);
    // hold upstream until the divider reports done
    assign stall_o    = is_div && !div_done;

    hilo_forward hilo_forward_inst (
        .aluop_i     (aluop_i),
        .hilo_data_i (hilo_data_i),
        .mem_bp      (mem_bp),
        .wb_bp       (wb_bp),
        .hilo_fwd_o  (hilo_fwd)
    );

    int_alu int_alu_inst (
        .aluop_i     (aluop_i),
        .instr_i     (instr_i),
        .rs_data_i   (rs_data_i),
        .rt_data_i   (rt_data_i),
        .pc_return_i (pc_return_i),
        .hilo_fwd_i  (hilo_fwd),
        .dest_addr_i (dest_addr_i),
        .alu_data_o  (alu_data_o),
        .wb_addr_o   (wb_addr_o),
        .overflow_o  (overflow_o)
    );

    hilo_result hilo_result_inst (
        .aluop_i     (aluop_i),
        .rs_data_i   (rs_data_i),
        .rt_data_i   (rt_data_i),
        .quotient_i  (quotient),
        .remainder_i (remainder),
        .hi_data_o   (hi_data_o),
        .lo_data_o   (lo_data_o)
    );

    seq_divider #(
        .DIV_CYCLES (DIV_CYCLES)
    ) seq_divider_inst (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .start_i     (is_div),
        .signed_i    (div_signed),
        .dividend_i  (rs_data_i),
        .divisor_i   (rt_data_i),
        .quotient_o  (quotient),
        .remainder_o (remainder),
        .done_o      (div_done)
    );

endmodule

//--- bench/ex_stage_properties.sv
`timescale 1ns/1ps

module ex_stage_properties import ex_pkg::*; (
    input logic     clk,
    input logic     rst_n_i,
    input aluop_e   aluop_i,
    input logic     stall_o,
    input logic     overflow_o,
    input reg_idx_t wb_addr_o
);

    int unsigned fail_cnt = 0;

    // only the divider stalls the stage
    stall_needs_div: assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_o |-> (aluop_i == ALUOP_DIV || aluop_i == ALUOP_DIVU))
        else begin
            fail_cnt++;
            $error("stall_o high without a divide");
        end

    overflow_kills_write: assert property (@(posedge clk) disable iff (!rst_n_i)
        overflow_o |-> (wb_addr_o == ZERO_REG))
        else begin
            fail_cnt++;
            $error("overflow_o high with a nonzero wb_addr_o");
        end

    no_stall_after_reset: assert property (@(posedge clk)
        $rose(rst_n_i) |-> !stall_o)
        else begin
            fail_cnt++;
            $error("stall_o high in the first cycle after reset");
        end

endmodule

bind ex_stage ex_stage_properties ex_stage_properties_inst (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .aluop_i    (aluop_i),
    .stall_o    (stall_o),
    .overflow_o (overflow_o),
    .wb_addr_o  (wb_addr_o)
);

//--- bench/tb_ex_stage.sv
`timescale 1ns/1ps

module tb_ex_stage import ex_pkg::*; ();

    localparam int DIV_CYCLES = 33;
    localparam int N_RANDOM   = 320;
    localparam int N_OVF      = 20;
    localparam int N_DIV      = 40;
    // 400 single-cycle tests plus the divides, doubled
    localparam int TIMEOUT    = 2 * (400 + N_DIV * (DIV_CYCLES + 2));

    logic     clk = 1'b0;
    logic     rst_n_i;
    aluop_e   aluop_i;
    word_t    instr_i, rs_data_i, rt_data_i, pc_return_i, hilo_data_i;
    reg_idx_t dest_addr_i;
    logic     mem_hi_we_i, mem_lo_we_i, wb_hi_we_i, wb_lo_we_i;
    word_t    mem_hi_data_i, mem_lo_data_i, wb_hi_data_i, wb_lo_data_i;
    word_t    alu_data_o, hi_data_o, lo_data_o;
    reg_idx_t wb_addr_o;
    logic     overflow_o, stall_o;

    word_t    exp_alu, exp_hi, exp_lo;
    reg_idx_t exp_wb;
    logic     exp_ovf;
    aluop_e   ops_q[$];
    int       cycle_cnt = 0;

    ex_stage #(.DIV_CYCLES(DIV_CYCLES)) ex_stage_inst (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            $display("Timeout after %0d cycles, the DUT stopped making progress", cycle_cnt);
            $display("Something failed");
            $fatal(1, "timeout");
        end
    end

    always @(ex_stage_inst.ex_stage_properties_inst.fail_cnt) begin
        if (ex_stage_inst.ex_stage_properties_inst.fail_cnt != 0) begin
            $display("An assertion in ex_stage_properties failed at %0t", $time);
            $display("Something failed");
            $fatal(1, "assertion failure");
        end
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %h, expected %h (op %s)",
                     $time, name, got, exp, aluop_i.name());
            $display("Something failed");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %0d, expected %0d (op %s)",
                     $time, name, got, exp, aluop_i.name());
            $display("Something failed");
            $fatal(1, "register index mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %b, expected %b (op %s)",
                     $time, name, got, exp, aluop_i.name());
            $display("Something failed");
            $fatal(1, "bit mismatch");
        end
    endtask

    task automatic randomize_inputs();
        instr_i       = $urandom();
        rs_data_i     = $urandom();
        rt_data_i     = $urandom();
        pc_return_i   = $urandom();
        hilo_data_i   = $urandom();
        dest_addr_i   = reg_idx_t'($urandom());
        mem_hi_we_i   = 1'($urandom_range(0, 1));
        mem_lo_we_i   = 1'($urandom_range(0, 1));
        wb_hi_we_i    = 1'($urandom_range(0, 1));
        wb_lo_we_i    = 1'($urandom_range(0, 1));
        mem_hi_data_i = $urandom();
        mem_lo_data_i = $urandom();
        wb_hi_data_i  = $urandom();
        wb_lo_data_i  = $urandom();
    endtask

    // reference model of the stage, from the current inputs
    task automatic compute_expected();
        int         a;
        int         b;
        int         imm_s;
        longint     wide;
        logic [4:0] sa;
        word_t      zimm;
        dword_t     hilo;
        a     = $signed(rs_data_i);
        b     = $signed(rt_data_i);
        imm_s = $signed({{16{instr_i[15]}}, instr_i[15:0]});
        zimm  = {16'h0000, instr_i[15:0]};
        sa    = instr_i[10:6];
        case (aluop_i)
            ALUOP_ADD:  wide = longint'(a) + longint'(b);
            ALUOP_ADDI: wide = longint'(a) + longint'(imm_s);
            ALUOP_SUB:  wide = longint'(a) - longint'(b);
            default:    wide = 0;
        endcase
        // true sum does not fit in 32 signed bits
        exp_ovf = (wide != longint'(int'(wide)));
        case (aluop_i)
            ALUOP_ADD, ALUOP_ADDU: exp_alu = word_t'(a + b);
            ALUOP_ADDI, ALUOP_ADDIU, ALUOP_LB, ALUOP_LBU, ALUOP_LH, ALUOP_LHU,
            ALUOP_LW, ALUOP_SB, ALUOP_SH, ALUOP_SW: exp_alu = word_t'(a + imm_s);
            ALUOP_SUB, ALUOP_SUBU: exp_alu = word_t'(a - b);
            ALUOP_SLT:   exp_alu = {31'b0, a < b};
            ALUOP_SLTI:  exp_alu = {31'b0, a < imm_s};
            ALUOP_SLTU:  exp_alu = {31'b0, rs_data_i < rt_data_i};
            ALUOP_SLTIU: exp_alu = {31'b0, rs_data_i < word_t'(imm_s)};
            ALUOP_AND:   exp_alu = rs_data_i & rt_data_i;
            ALUOP_ANDI:  exp_alu = rs_data_i & zimm;
            ALUOP_OR:    exp_alu = rs_data_i | rt_data_i;
            ALUOP_ORI:   exp_alu = rs_data_i | zimm;
            ALUOP_XOR:   exp_alu = rs_data_i ^ rt_data_i;
            ALUOP_XORI:  exp_alu = rs_data_i ^ zimm;
            ALUOP_NOR:   exp_alu = ~(rs_data_i | rt_data_i);
            ALUOP_LUI:   exp_alu = {instr_i[15:0], 16'h0000};
            ALUOP_SLL:   exp_alu = rt_data_i << sa;
            ALUOP_SLLV:  exp_alu = rt_data_i << rs_data_i[4:0];
            ALUOP_SRL:   exp_alu = rt_data_i >> sa;
            ALUOP_SRLV:  exp_alu = rt_data_i >> rs_data_i[4:0];
            ALUOP_SRA:   exp_alu = word_t'(b >>> sa);
            ALUOP_SRAV:  exp_alu = word_t'(b >>> rs_data_i[4:0]);
            ALUOP_JAL, ALUOP_JALR, ALUOP_BGEZAL, ALUOP_BLTZAL: exp_alu = pc_return_i;
            // memory stage first, then writeback, then register file
            ALUOP_MFHI:  exp_alu = mem_hi_we_i ? mem_hi_data_i
                                 : wb_hi_we_i ? wb_hi_data_i : hilo_data_i;
            ALUOP_MFLO:  exp_alu = mem_lo_we_i ? mem_lo_data_i
                                 : wb_lo_we_i ? wb_lo_data_i : hilo_data_i;
            default:     exp_alu = '0;
        endcase
        exp_wb = exp_ovf ? ZERO_REG
               : (aluop_i inside {ALUOP_JAL, ALUOP_BGEZAL, ALUOP_BLTZAL}) ? LINK_REG
               : dest_addr_i;
        case (aluop_i)
            ALUOP_MULT:  hilo = dword_t'(longint'(a) * longint'(b));
            ALUOP_MULTU: hilo = {32'h0, rs_data_i} * {32'h0, rt_data_i};
            ALUOP_MTHI, ALUOP_MTLO: hilo = {rs_data_i, rs_data_i};
            ALUOP_DIV:   hilo = {word_t'(a % b), word_t'(a / b)};
            ALUOP_DIVU:  hilo = {rs_data_i % rt_data_i, rs_data_i / rt_data_i};
            default:     hilo = '0;
        endcase
        exp_hi = hilo[63:32];
        exp_lo = hilo[31:0];
    endtask

    task automatic check_all();
        check_word("alu_data_o", alu_data_o, exp_alu);
        check_reg("wb_addr_o", wb_addr_o, exp_wb);
        check_bit("overflow_o", overflow_o, exp_ovf);
        check_word("hi_data_o", hi_data_o, exp_hi);
        check_word("lo_data_o", lo_data_o, exp_lo);
        check_bit("stall_o", stall_o, 1'b0);
    endtask

    task automatic run_single(input aluop_e op);
        aluop_i = op;
        compute_expected();
        @(negedge clk);
        check_all();
    endtask

    task automatic run_divide(input aluop_e op);
        int cycles;
        randomize_inputs();
        // mix of small and negative divisors
        rt_data_i = rt_data_i >> $urandom_range(0, 31);
        if ($urandom_range(0, 1) == 1) begin
            rt_data_i = -rt_data_i;
        end
        if (rt_data_i == '0 || (rs_data_i == 32'h8000_0000 && rt_data_i == '1)) begin
            rt_data_i = 32'd3;
        end
        aluop_i = op;
        compute_expected();
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (stall_o);
        check_word("stall_o length", word_t'(cycles), word_t'(DIV_CYCLES));
        check_all();
        // one idle cycle so the divider can return to idle
        aluop_i = ALUOP_NOP;
        @(negedge clk);
    endtask

    initial begin
        aluop_e op;
        void'($urandom(32'h7a4d_cfb6));
        rst_n_i = 1'b0;
        aluop_i = ALUOP_NOP;
        randomize_inputs();
        op = op.first();
        do begin
            if (op != ALUOP_DIV && op != ALUOP_DIVU) begin
                ops_q.push_back(op);
            end
            op = op.next();
        end while (op != op.first());
        repeat (5) @(negedge clk);
        rst_n_i = 1'b1;
        repeat (N_RANDOM) begin
            randomize_inputs();
            run_single(ops_q[$urandom_range(0, ops_q.size() - 1)]);
        end
        // operands that overflow signed add and subtract
        repeat (N_OVF) begin
            randomize_inputs();
            rs_data_i     = {18'h1_ffff, 14'($urandom())};
            rt_data_i     = {2'b01, 30'($urandom())};
            instr_i[15:0] = {2'b01, 14'($urandom())};
            run_single(ALUOP_ADD);
            run_single(ALUOP_ADDU);
            run_single(ALUOP_ADDI);
            rt_data_i = {2'b10, 30'($urandom())};
            run_single(ALUOP_SUB);
        end
        repeat (N_DIV) begin
            run_divide(1'($urandom_range(0, 1)) ? ALUOP_DIV : ALUOP_DIVU);
        end
        $display("Everything OK");
        $finish;
    end

endmodule

//--- sources.f
hw/ex_pkg.sv
hw/hilo_bypass_if.sv
hw/hilo_forward.sv
hw/int_alu.sv
hw/hilo_result.sv
hw/seq_divider.sv
hw/ex_stage.sv
bench/ex_stage_properties.sv
bench/tb_ex_stage.sv

//--- run.sh
#!/bin/sh
# build tb_ex_stage with Verilator, run it, and scan the log for the fail line
rm -f sim.log
verilator --binary --timing --assert -f sources.f --top-module tb_ex_stage -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Something failed" sim.log && { echo "FAIL"; exit 1; } || echo "PASS"
